//--- files.f
rtl/npu_isa_pkg.sv
rtl/npu_mem_pkg.sv
rtl/scratchpad_ram.sv
rtl/scratchpad_arbiter.sv
rtl/matrix_add_engine.sv
rtl/maxpool_engine.sv
rtl/npu_dispatch.sv
rtl/npu_top.sv
tb/tb_clock_gen.sv
tb/npu_tb.sv

//--- rtl/matrix_add_engine.sv
`default_nettype none

module matrix_add_engine (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  start,
    input  npu_mem_pkg::sp_addr_t src1_addr,
    input  npu_mem_pkg::sp_addr_t src2_addr,
    input  npu_mem_pkg::sp_addr_t dest_addr,
    input  npu_isa_pkg::dim_t     rows,
    input  npu_isa_pkg::dim_t     cols,
    output logic                  busy,
    output logic                  req,
    output logic                  write,
    output npu_mem_pkg::sp_addr_t addr,
    output npu_mem_pkg::sp_data_t wdata,
    input  logic                  gnt,
    input  logic                  rvalid,
    input  npu_mem_pkg::sp_data_t rdata
);
    import npu_mem_pkg::*;

    typedef enum logic [2:0] {
        s_idle, s_read_a, s_wait_a, s_read_b, s_wait_b, s_write
    } state_t;

    state_t   state;
    sp_addr_t base_a, base_b, base_d;
    sp_addr_t elem, total;
    sp_data_t a_val, sum;

    assign busy  = (state != s_idle);
    assign req   = (state == s_read_a) || (state == s_read_b) || (state == s_write);
    assign write = (state == s_write);
    assign wdata = sum;

    // all three matrices share the element index
    always_comb begin
        case (state)
            s_read_a: addr = base_a + elem;
            s_read_b: addr = base_b + elem;
            default:  addr = base_d + elem;
        endcase
    end

    // ------------------------------
    // per element sequence
    // ------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:   if (start) state <= s_read_a;
                s_read_a: if (gnt) state <= s_wait_a;
                s_wait_a: if (rvalid) state <= s_read_b;
                s_read_b: if (gnt) state <= s_wait_b;
                s_wait_b: if (rvalid) state <= s_write;
                s_write: begin
                    if (gnt) begin
                        state <= (elem == total - 1'b1) ? s_idle : s_read_a;
                    end
                end
                default:  state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == s_idle && start) begin
            base_a <= src1_addr;
            base_b <= src2_addr;
            base_d <= dest_addr;
            total  <= sp_addr_t'(rows) * sp_addr_t'(cols);
            elem   <= '0;
        end
        if (state == s_wait_a && rvalid) begin
            a_val <= rdata;
        end
        // wraps at 16 bits
        if (state == s_wait_b && rvalid) begin
            sum <= a_val + rdata;
        end
        if (state == s_write && gnt) begin
            elem <= elem + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/maxpool_engine.sv
`default_nettype none

module maxpool_engine (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  start,
    input  npu_mem_pkg::sp_addr_t src1_addr,
    input  npu_mem_pkg::sp_addr_t dest_addr,
    input  npu_isa_pkg::dim_t     rows,
    input  npu_isa_pkg::dim_t     cols,
    output logic                  busy,
    output logic                  req,
    output logic                  write,
    output npu_mem_pkg::sp_addr_t addr,
    output npu_mem_pkg::sp_data_t wdata,
    input  logic                  gnt,
    input  logic                  rvalid,
    input  npu_mem_pkg::sp_data_t rdata
);
    import npu_isa_pkg::*;
    import npu_mem_pkg::*;

    typedef enum logic [1:0] {s_idle, s_read, s_wait, s_write} state_t;

    state_t     state;
    sp_addr_t   base_s, base_d;
    dim_t       cols_q, out_rows, out_cols;
    dim_t       win_r, win_c;
    logic [1:0] pix;
    sp_addr_t   out_idx;
    sp_data_t   max_val;
    sp_addr_t   src_row, src_col;
    logic       last_window;

    // pix walks the window row-major: bit 1 is row, bit 0 is column
    assign src_row = sp_addr_t'({win_r, 1'b0}) + sp_addr_t'(pix[1]);
    assign src_col = sp_addr_t'({win_c, 1'b0}) + sp_addr_t'(pix[0]);

    assign last_window = (win_c == out_cols - 1'b1) && (win_r == out_rows - 1'b1);

    assign busy  = (state != s_idle);
    assign req   = (state == s_read) || (state == s_write);
    assign write = (state == s_write);
    assign wdata = max_val;
    assign addr  = (state == s_write) ? base_d + out_idx
                                      : base_s + src_row * sp_addr_t'(cols_q) + src_col;

    // ------------------------------
    // window sequence
    // ------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:  if (start) state <= s_read;
                s_read:  if (gnt) state <= s_wait;
                s_wait: begin
                    if (rvalid) begin
                        state <= (pix == 2'd3) ? s_write : s_read;
                    end
                end
                s_write: if (gnt) state <= last_window ? s_idle : s_read;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == s_idle && start) begin
            base_s   <= src1_addr;
            base_d   <= dest_addr;
            cols_q   <= cols;
            // odd trailing row or column drops out here
            out_rows <= rows >> 1;
            out_cols <= cols >> 1;
            win_r    <= '0;
            win_c    <= '0;
            pix      <= '0;
            out_idx  <= '0;
        end
        if (state == s_wait && rvalid) begin
            pix <= pix + 1'b1;
            // first pixel seeds the running max
            if (pix == 2'd0 || $signed(rdata) > $signed(max_val)) begin
                max_val <= rdata;
            end
        end
        if (state == s_write && gnt) begin
            out_idx <= out_idx + 1'b1;
            if (win_c == out_cols - 1'b1) begin
                win_c <= '0;
                win_r <= win_r + 1'b1;
            end else begin
                win_c <= win_c + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/npu_dispatch.sv
`default_nettype none

module npu_dispatch (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  npu_isa_pkg::cmd_word_t cmd_word,
    output logic                   cmd_ready,
    output logic                   add_start,
    output logic                   pool_start,
    output npu_mem_pkg::sp_addr_t  src1_addr,
    output npu_mem_pkg::sp_addr_t  src2_addr,
    output npu_mem_pkg::sp_addr_t  dest_addr,
    output npu_isa_pkg::dim_t      rows,
    output npu_isa_pkg::dim_t      cols,
    input  logic                   add_busy,
    input  logic                   pool_busy,
    output logic                   done_valid,
    output npu_isa_pkg::opcode_t   done_op
);
    import npu_isa_pkg::*;

    logic    cmd_full;
    opcode_t cmd_op;
    logic    issue_add, issue_pool, drop_cmd;
    logic    add_busy_q, pool_busy_q;
    logic    add_fall, pool_fall;
    logic    add_pend, pool_pend;

    assign cmd_ready  = !cmd_full;
    assign issue_add  = cmd_full && (cmd_op == op_add) && !add_busy;
    assign issue_pool = cmd_full && (cmd_op == op_pool) && !pool_busy;
    // nop and unknown opcodes leave without a start
    assign drop_cmd   = cmd_full && (cmd_op != op_add) && (cmd_op != op_pool);

    // ------------------------------
    // decode and issue
    // ------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            cmd_full   <= 1'b0;
            add_start  <= 1'b0;
            pool_start <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_full <= 1'b1;
            end else if (issue_add || issue_pool || drop_cmd) begin
                cmd_full <= 1'b0;
            end
            add_start  <= issue_add;
            pool_start <= issue_pool;
        end
    end

    // operands stay put while the started engine samples them
    always_ff @(posedge CLOCK_50) begin
        if (cmd_valid && cmd_ready) begin
            cmd_op    <= opcode_t'(cmd_word[CMD_OP_LSB +: OP_W]);
            src1_addr <= cmd_word[CMD_SRC1_LSB +: CMD_ADDR_W];
            src2_addr <= cmd_word[CMD_SRC2_LSB +: CMD_ADDR_W];
            dest_addr <= cmd_word[CMD_DEST_LSB +: CMD_ADDR_W];
            rows      <= cmd_word[CMD_ROWS_LSB +: DIM_W];
            cols      <= cmd_word[CMD_COLS_LSB +: DIM_W];
        end
    end

    // ------------------------------
    // completion
    // ------------------------------
    assign add_fall  = add_busy_q && !add_busy;
    assign pool_fall = pool_busy_q && !pool_busy;

    // add owns the report slot, pool waits one cycle behind it
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            add_busy_q  <= 1'b0;
            pool_busy_q <= 1'b0;
            add_pend    <= 1'b0;
            pool_pend   <= 1'b0;
            done_valid  <= 1'b0;
            done_op     <= op_nop;
        end else begin
            add_busy_q  <= add_busy;
            pool_busy_q <= pool_busy;
            add_pend    <= add_fall;
            pool_pend   <= pool_fall || (pool_pend && add_pend);
            done_valid  <= add_pend || pool_pend;
            if (add_pend) begin
                done_op <= op_add;
            end else if (pool_pend) begin
                done_op <= op_pool;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/npu_isa_pkg.sv
`default_nettype none

package npu_isa_pkg;

    // ------------------------------
    // command word layout
    // ------------------------------
    localparam int OP_W       = 4;
    localparam int CMD_ADDR_W = 12;
    localparam int DIM_W      = 6;
    localparam int CMD_W      = OP_W + 3 * CMD_ADDR_W + 2 * DIM_W;

    // field positions, top down: opcode, src1, src2, dest, rows, cols
    localparam int CMD_COLS_LSB = 0;
    localparam int CMD_ROWS_LSB = CMD_COLS_LSB + DIM_W;
    localparam int CMD_DEST_LSB = CMD_ROWS_LSB + DIM_W;
    localparam int CMD_SRC2_LSB = CMD_DEST_LSB + CMD_ADDR_W;
    localparam int CMD_SRC1_LSB = CMD_SRC2_LSB + CMD_ADDR_W;
    localparam int CMD_OP_LSB   = CMD_SRC1_LSB + CMD_ADDR_W;

    typedef logic [CMD_W-1:0] cmd_word_t;

    // matrix row or column count
    typedef logic [DIM_W-1:0] dim_t;

    typedef enum logic [OP_W-1:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_pool = 4'd8
    } opcode_t;

endpackage

`default_nettype wire

//--- rtl/npu_mem_pkg.sv
`default_nettype none

package npu_mem_pkg;

    // scratchpad geometry
    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 16;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    typedef logic [ADDR_W-1:0] sp_addr_t;
    // signed for pooling, wraps for addition
    typedef logic [DATA_W-1:0] sp_data_t;

    // ------------------------------
    // arbiter requesters
    // ------------------------------
    localparam int NUM_REQ  = 3;
    localparam int REQ_W    = $clog2(NUM_REQ);
    localparam int REQ_HOST = 0;
    localparam int REQ_ADD  = 1;
    localparam int REQ_POOL = 2;

    typedef logic [REQ_W-1:0] req_id_t;

endpackage

`default_nettype wire

//--- rtl/npu_top.sv
`default_nettype none

module npu_top (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  npu_isa_pkg::cmd_word_t cmd_word,
    output logic                   cmd_ready,
    input  logic                   host_valid,
    input  logic                   host_write,
    input  npu_mem_pkg::sp_addr_t  host_addr,
    input  npu_mem_pkg::sp_data_t  host_wdata,
    output logic                   host_ready,
    output logic                   host_rvalid,
    output npu_mem_pkg::sp_data_t  host_rdata,
    output logic                   done_valid,
    output npu_isa_pkg::opcode_t   done_op
);
    import npu_isa_pkg::*;
    import npu_mem_pkg::*;

    logic     add_start, pool_start;
    logic     add_busy, pool_busy;
    sp_addr_t src1_addr, src2_addr, dest_addr;
    dim_t     rows, cols;

    // one slot per requester
    wire [NUM_REQ-1:0] arb_req, arb_write, arb_gnt, arb_rvalid;
    wire sp_addr_t     arb_addr  [NUM_REQ];
    wire sp_data_t     arb_wdata [NUM_REQ];
    sp_data_t          arb_rdata;

    sp_addr_t mem_addr;
    sp_data_t mem_wdata, mem_rdata;
    logic     mem_we;

    // ------------------------------
    // host port onto the arbiter
    // ------------------------------
    assign arb_req[REQ_HOST]   = host_valid;
    assign arb_write[REQ_HOST] = host_write;
    assign arb_addr[REQ_HOST]  = host_addr;
    assign arb_wdata[REQ_HOST] = host_wdata;
    assign host_ready          = arb_gnt[REQ_HOST];
    assign host_rvalid         = arb_rvalid[REQ_HOST];
    assign host_rdata          = arb_rdata;

    npu_dispatch i_dispatch (
        .CLOCK_50(CLOCK_50), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word), .cmd_ready(cmd_ready),
        .add_start(add_start), .pool_start(pool_start),
        .src1_addr(src1_addr), .src2_addr(src2_addr), .dest_addr(dest_addr),
        .rows(rows), .cols(cols),
        .add_busy(add_busy), .pool_busy(pool_busy),
        .done_valid(done_valid), .done_op(done_op)
    );

    matrix_add_engine i_add (
        .CLOCK_50(CLOCK_50), .reset(reset), .start(add_start),
        .src1_addr(src1_addr), .src2_addr(src2_addr), .dest_addr(dest_addr),
        .rows(rows), .cols(cols), .busy(add_busy),
        .req(arb_req[REQ_ADD]), .write(arb_write[REQ_ADD]),
        .addr(arb_addr[REQ_ADD]), .wdata(arb_wdata[REQ_ADD]),
        .gnt(arb_gnt[REQ_ADD]), .rvalid(arb_rvalid[REQ_ADD]), .rdata(arb_rdata)
    );

    maxpool_engine i_pool (
        .CLOCK_50(CLOCK_50), .reset(reset), .start(pool_start),
        .src1_addr(src1_addr), .dest_addr(dest_addr),
        .rows(rows), .cols(cols), .busy(pool_busy),
        .req(arb_req[REQ_POOL]), .write(arb_write[REQ_POOL]),
        .addr(arb_addr[REQ_POOL]), .wdata(arb_wdata[REQ_POOL]),
        .gnt(arb_gnt[REQ_POOL]), .rvalid(arb_rvalid[REQ_POOL]), .rdata(arb_rdata)
    );

    scratchpad_arbiter i_arbiter (
        .CLOCK_50(CLOCK_50), .reset(reset),
        .req(arb_req), .write(arb_write), .addr(arb_addr), .wdata(arb_wdata),
        .gnt(arb_gnt), .rvalid(arb_rvalid), .rdata(arb_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .mem_rdata(mem_rdata)
    );

    scratchpad_ram i_ram (
        .CLOCK_50(CLOCK_50),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .we(mem_we),
        .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/scratchpad_arbiter.sv
`default_nettype none

module scratchpad_arbiter (
    input  logic                            CLOCK_50,
    input  logic                            reset,
    input  logic [npu_mem_pkg::NUM_REQ-1:0] req,
    input  logic [npu_mem_pkg::NUM_REQ-1:0] write,
    input  npu_mem_pkg::sp_addr_t           addr  [npu_mem_pkg::NUM_REQ],
    input  npu_mem_pkg::sp_data_t           wdata [npu_mem_pkg::NUM_REQ],
    output logic [npu_mem_pkg::NUM_REQ-1:0] gnt,
    output logic [npu_mem_pkg::NUM_REQ-1:0] rvalid,
    output npu_mem_pkg::sp_data_t           rdata,
    output npu_mem_pkg::sp_addr_t           mem_addr,
    output npu_mem_pkg::sp_data_t           mem_wdata,
    output logic                            mem_we,
    input  npu_mem_pkg::sp_data_t           mem_rdata
);
    import npu_mem_pkg::*;

    req_id_t last_win;
    req_id_t winner;
    logic    found;
    logic    rd_pend;
    req_id_t rd_id;

    // ------------------------------
    // round-robin pick
    // ------------------------------
    // search starts one past the last winner
    always_comb begin : pick
        int cand;
        found  = 1'b0;
        winner = last_win;
        for (int i = 1; i <= NUM_REQ; i++) begin
            cand = (int'(last_win) + i) % NUM_REQ;
            if (!found && req[cand]) begin
                found  = 1'b1;
                winner = req_id_t'(cand);
            end
        end
    end

    always_comb begin
        gnt = '0;
        if (found) begin
            gnt[winner] = 1'b1;
        end
    end

    assign mem_addr  = addr[winner];
    assign mem_wdata = wdata[winner];
    assign mem_we    = found && write[winner];

    // read data goes back to whoever read last cycle
    always_comb begin
        rvalid = '0;
        if (rd_pend) begin
            rvalid[rd_id] = 1'b1;
        end
    end

    assign rdata = mem_rdata;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            last_win <= req_id_t'(NUM_REQ - 1);
            rd_pend  <= 1'b0;
        end else begin
            if (found) begin
                last_win <= winner;
            end
            rd_pend <= found && !write[winner];
        end
    end

    always_ff @(posedge CLOCK_50) begin
        rd_id <= winner;
    end

endmodule

`default_nettype wire

//--- rtl/scratchpad_ram.sv
`default_nettype none

module scratchpad_ram (
    input  logic                  CLOCK_50,
    input  npu_mem_pkg::sp_addr_t addr,
    input  npu_mem_pkg::sp_data_t wdata,
    input  logic                  we,
    output npu_mem_pkg::sp_data_t rdata
);
    import npu_mem_pkg::*;

    sp_data_t mem [MEM_DEPTH];

    // single port, read data registered
    always_ff @(posedge CLOCK_50) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- tb/npu_tb.sv
`default_nettype none

module npu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import npu_isa_pkg::*;
    import npu_mem_pkg::*;

    // ------------------------------
    // run length
    // ------------------------------
    // accesses per test: host writes, engine accesses, host reads
    localparam int ACC_ADD    = 40 + 60 + 20;
    localparam int ACC_POOL   = 24 + 30 + 6;
    localparam int ACC_PAIR   = 60 + 30 + 20 + 26;
    localparam int ACC_QUEUE  = 120 + 40 + 20 + 4;
    // a grant can trail the other two requesters, then one cycle of read return
    localparam int CYC_PER_ACC    = NUM_REQ + 1;
    localparam int TIMEOUT_CYCLES = 2 * CYC_PER_ACC * (ACC_ADD + ACC_POOL + ACC_PAIR + ACC_QUEUE);

    localparam sp_addr_t MAT_A    = 12'h000;
    localparam sp_addr_t MAT_B    = 12'h020;
    localparam sp_addr_t MAT_P    = 12'h100;
    localparam logic [3:0] OP_BAD = 4'hf;

    logic      CLOCK_50;
    logic      reset;
    logic      cmd_valid;
    cmd_word_t cmd_word;
    logic      cmd_ready;
    logic      host_valid;
    logic      host_write;
    sp_addr_t  host_addr;
    sp_data_t  host_wdata;
    logic      host_ready;
    logic      host_rvalid;
    sp_data_t  host_rdata;
    logic      done_valid;
    opcode_t   done_op;

    sp_data_t    model [MEM_DEPTH];
    sp_data_t    exp_rdata;
    logic [31:0] rng_state = 32'd95;
    int          cycle_count;
    int          pending_add;
    int          pending_pool;
    int          accepted_known;
    int          done_count;
    logic        add_waited;
    logic        cmd_fire;
    logic [3:0]  sent_op;

    tb_clock_gen i_clock_gen (
        .CLOCK_50(CLOCK_50),
        .reset(reset)
    );

    npu_top i_dut (
        .CLOCK_50(CLOCK_50), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word), .cmd_ready(cmd_ready),
        .host_valid(host_valid), .host_write(host_write),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_ready(host_ready), .host_rvalid(host_rvalid), .host_rdata(host_rdata),
        .done_valid(done_valid), .done_op(done_op)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic sp_data_t next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    // fields from the top: opcode, src1, src2, dest, rows, cols
    function automatic cmd_word_t make_cmd(input logic [3:0] op, input sp_addr_t s1,
                                           input sp_addr_t s2, input sp_addr_t d,
                                           input int rows, input int cols);
        return {op, s1, s2, d, dim_t'(rows), dim_t'(cols)};
    endfunction

    // ------------------------------
    // bookkeeping
    // ------------------------------
    assign cmd_fire = cmd_valid && cmd_ready;
    assign sent_op  = cmd_word[CMD_OP_LSB +: OP_W];

    always @(posedge CLOCK_50) begin
        if (reset) begin
            pending_add    <= 0;
            pending_pool   <= 0;
            accepted_known <= 0;
            done_count     <= 0;
            add_waited     <= 1'b0;
        end else begin
            pending_add  <= pending_add + int'(cmd_fire && sent_op == op_add)
                                        - int'(done_valid && done_op == op_add);
            pending_pool <= pending_pool + int'(cmd_fire && sent_op == op_pool)
                                         - int'(done_valid && done_op == op_pool);
            accepted_known <= accepted_known
                              + int'(cmd_fire && (sent_op == op_add || sent_op == op_pool));
            done_count <= done_count + int'(done_valid);
            if (cmd_valid && !cmd_ready && pending_add >= 2) begin
                add_waited <= 1'b1;
            end
        end
    end

    // expected data for the host read granted this cycle
    always @(posedge CLOCK_50) begin
        if (host_valid && host_ready && !host_write) begin
            exp_rdata <= model[host_addr];
        end
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            fail_now("run timed out before all commands completed");
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_reset_state: assert property (@(posedge CLOCK_50)
        $fell(reset) |-> (cmd_ready && !done_valid && !host_rvalid))
        else fail_now($sformatf("Error: cmd_ready/done_valid/host_rvalid = %h/%h/%h, expected 1/0/0",
                                $sampled(cmd_ready), $sampled(done_valid),
                                $sampled(host_rvalid)));

    a_host_rdata: assert property (@(posedge CLOCK_50) disable iff (reset)
        host_rvalid |-> (host_rdata == exp_rdata))
        else fail_now($sformatf("Error: host_rdata = %h, expected %h",
                                $sampled(host_rdata), $sampled(exp_rdata)));

    a_done_op: assert property (@(posedge CLOCK_50) disable iff (reset)
        done_valid |-> (done_op == op_add || done_op == op_pool))
        else fail_now($sformatf("Error: done_op = %h, expected %h or %h",
                                $sampled(done_op), op_add, op_pool));

    a_add_done_owed: assert property (@(posedge CLOCK_50) disable iff (reset)
        (done_valid && done_op == op_add) |-> (pending_add > 0))
        else fail_now("add completion reported with no add outstanding");

    a_pool_done_owed: assert property (@(posedge CLOCK_50) disable iff (reset)
        (done_valid && done_op == op_pool) |-> (pending_pool > 0))
        else fail_now("pool completion reported with no pool outstanding");

    // a held add frees the decode slot only as the running add completes
    a_queued_add_held: assert property (@(posedge CLOCK_50) disable iff (reset)
        ($rose(cmd_ready) && pending_add >= 2) |-> ##1 (done_valid && done_op == op_add))
        else fail_now("cmd_ready rose while the first add was still running");

    // ------------------------------
    // host and command tasks
    // ------------------------------
    task automatic send_cmd(input cmd_word_t w);
        cmd_word  = w;
        cmd_valid = 1'b1;
        do @(posedge CLOCK_50); while (!cmd_ready);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic host_store(input sp_addr_t a, input sp_data_t d);
        host_valid = 1'b1;
        host_write = 1'b1;
        host_addr  = a;
        host_wdata = d;
        model[a]   = d;
        do @(posedge CLOCK_50); while (!host_ready);
        #2;
        host_valid = 1'b0;
    endtask

    task automatic host_load(input sp_addr_t a);
        host_valid = 1'b1;
        host_write = 1'b0;
        host_addr  = a;
        do @(posedge CLOCK_50); while (!host_ready);
        #2;
        host_valid = 1'b0;
        do @(posedge CLOCK_50); while (!host_rvalid);
        #2;
    endtask

    task automatic fill_random(input sp_addr_t base, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            host_store(sp_addr_t'(base + i), next_rand());
        end
    endtask

    task automatic read_back(input sp_addr_t base, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            host_load(sp_addr_t'(base + i));
        end
    endtask

    task automatic wait_idle();
        while (pending_add != 0 || pending_pool != 0) begin
            @(posedge CLOCK_50);
        end
        #2;
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    // wrapped sum, element by element in row-major order
    task automatic issue_add(input sp_addr_t s1, input sp_addr_t s2, input sp_addr_t d,
                             input int rows, input int cols);
        int i;
        for (i = 0; i < rows * cols; i++) begin
            model[sp_addr_t'(d + i)] = model[sp_addr_t'(s1 + i)] + model[sp_addr_t'(s2 + i)];
        end
        send_cmd(make_cmd(op_add, s1, s2, d, rows, cols));
    endtask

    // signed max of each 2x2 window, odd edge row or column left out
    task automatic issue_pool(input sp_addr_t s, input sp_addr_t d,
                              input int rows, input int cols);
        int       wr;
        int       wc;
        int       k;
        sp_data_t best;
        sp_data_t v;
        for (wr = 0; wr < rows / 2; wr++) begin
            for (wc = 0; wc < cols / 2; wc++) begin
                best = model[sp_addr_t'(s + 2 * wr * cols + 2 * wc)];
                for (k = 1; k < 4; k++) begin
                    v = model[sp_addr_t'(s + (2 * wr + k / 2) * cols + 2 * wc + k % 2)];
                    if ($signed(v) > $signed(best)) begin
                        best = v;
                    end
                end
                model[sp_addr_t'(d + wr * (cols / 2) + wc)] = best;
            end
        end
        send_cmd(make_cmd(op_pool, s, 12'h000, d, rows, cols));
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        cycle_count = 0;
        cmd_valid   = 1'b0;
        cmd_word    = '0;
        host_valid  = 1'b0;
        host_write  = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        wait (reset === 1'b0);

        // single add of two 4x5 matrices
        fill_random(MAT_A, 20);
        fill_random(MAT_B, 20);
        issue_add(MAT_A, MAT_B, 12'h040, 4, 5);
        wait_idle();
        read_back(12'h040, 20);

        // 6x4 pool down to 3x2
        fill_random(MAT_P, 24);
        issue_pool(MAT_P, 12'h140, 6, 4);
        wait_idle();
        read_back(12'h140, 6);

        // both engines at once with the host reading alongside
        issue_add(MAT_A, MAT_B, 12'h060, 4, 5);
        issue_pool(MAT_P, 12'h160, 6, 4);
        read_back(MAT_A, 20);
        wait_idle();
        read_back(12'h060, 20);
        read_back(12'h160, 6);

        // second add and a bad opcode queue behind a busy adder
        issue_add(MAT_A, MAT_B, 12'h080, 4, 5);
        issue_add(MAT_A, 12'h040, 12'h0a0, 4, 5);
        send_cmd(make_cmd(OP_BAD, MAT_A, MAT_B, 12'h200, 4, 5));
        issue_pool(MAT_P, 12'h180, 5, 5);
        wait_idle();
        read_back(12'h080, 20);
        read_back(12'h0a0, 20);
        read_back(12'h180, 4);

        assert (accepted_known == done_count)
            else fail_now($sformatf("Error: done_count = %h, expected %h",
                                    done_count, accepted_known));
        assert (add_waited)
            else fail_now("no command was ever held back behind a busy adder");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic CLOCK_50,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        CLOCK_50 = 1'b0;
        forever #HALF_PERIOD CLOCK_50 = ~CLOCK_50;
    end

    // release just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #2 reset = 1'b0;
    end

endmodule

`default_nettype wire
